// ==== logic/mem_bus_pkg.sv ====
/*
 * memory bus definitions
 * command encoding and widths shared by the data-memory port and the
 * write-back port of the memory stage
 */
package mem_bus_pkg;

  //////////////////////////////
  // bus command
  //////////////////////////////
  typedef enum logic [1:0] {
    bus_none  = 2'h0,  // idle, nothing on the bus
    bus_load  = 2'h1,  // word read, answered later by tag
    bus_store = 2'h2   // word write
  } bus_cmd_e;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int TAG_W  = 4;   // response/tag, zero means nothing accepted
  localparam int ADDR_W = 64;  // byte address
  localparam int DATA_W = 64;  // one word per transfer

  localparam int WORD_ADDR_LO    = 3;   // low bits select a byte inside the word
  localparam int CACHE_ADDR_BITS = 13;  // word-address bits seen by the cache

endpackage

// ==== logic/dcache_pkg.sv ====
/*
 * data cache definitions
 * line layout, miss controller states and the index/tag split, which
 * depends on how many ways the cache is built with
 */
package dcache_pkg;

  localparam int NUM_LINES = 32;  // total lines, one word each

  // index bits for a given way count
  function automatic int set_bits(input int ways);
    return $clog2(NUM_LINES / ways);
  endfunction

  // what is left of the cached word address after the index
  function automatic int tag_bits(input int ways);
    return mem_bus_pkg::CACHE_ADDR_BITS - set_bits(ways);
  endfunction

  //////////////////////////////
  // one cache line
  //////////////////////////////
  typedef struct packed {
    logic [mem_bus_pkg::DATA_W-1:0]          data;
    logic [mem_bus_pkg::CACHE_ADDR_BITS-1:0] tag;    // upper tag_bits compared
    logic                                    valid;
    logic                                    dirty;  // differs from memory
  } cache_line_t;

  // load miss controller
  typedef enum logic [1:0] {
    idle,       // serving hits and stores
    req,        // load request on the data-memory port
    wait_data   // request accepted, waiting for our tag
  } ctrl_state_e;

endpackage

// ==== logic/evict_if.sv ====
`timescale 1ns/1ps
/*
 * eviction channel from the data cache to the eviction buffer
 * one dirty line per push pulse, buffer status flows back
 */
interface evict_if #(
  parameter int NUM_WAYS = 2
) ();

  // tag, index and the zero byte offset
  localparam int LINE_ADDR_W = dcache_pkg::tag_bits(NUM_WAYS)
                             + dcache_pkg::set_bits(NUM_WAYS)
                             + mem_bus_pkg::WORD_ADDR_LO;

  logic [LINE_ADDR_W-1:0]         line_addr;  // byte address of the victim
  logic [mem_bus_pkg::DATA_W-1:0] line_data;
  logic                           push;       // single cycle, only while !full
  logic                           full;
  logic                           empty;      // nothing left to write back

  modport producer (output line_addr, line_data, push, input full, empty);

  modport consumer (input line_addr, line_data, push, output full, empty);

endinterface

// ==== logic/dcache.sv ====
`timescale 1ns/1ps
/*
 * write-back, write-allocate data cache, one word per line
 * load hits answer in the same cycle, a load miss is fetched over the
 * tagged data-memory port, dirty victims are pushed to the eviction buffer
 */
module dcache #(
  parameter int NUM_WAYS = 2
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              rd_mem,
  input  logic [mem_bus_pkg::ADDR_W-1:0]    rd_addr,
  input  logic                              wr_mem,
  input  logic [mem_bus_pkg::ADDR_W-1:0]    wr_addr,
  input  logic [mem_bus_pkg::DATA_W-1:0]    wr_data,
  input  logic [mem_bus_pkg::TAG_W-1:0]     dmem2proc_response,
  input  logic [mem_bus_pkg::TAG_W-1:0]     dmem2proc_tag,
  input  logic [mem_bus_pkg::DATA_W-1:0]    dmem2proc_data,
  output logic [mem_bus_pkg::DATA_W-1:0]    rd_data,
  output logic                              rd_valid,
  output mem_bus_pkg::bus_cmd_e             proc2dmem_command,
  output logic [mem_bus_pkg::ADDR_W-1:0]    proc2dmem_addr,
  evict_if.producer                         evict
);

  localparam int NUM_SETS    = dcache_pkg::NUM_LINES / NUM_WAYS;
  localparam int SET_W       = dcache_pkg::set_bits(NUM_WAYS);
  localparam int LT_W        = dcache_pkg::tag_bits(NUM_WAYS);
  localparam int WA_W        = mem_bus_pkg::CACHE_ADDR_BITS;  // cached word address
  localparam int LO          = mem_bus_pkg::WORD_ADDR_LO;
  localparam int ADDR_W      = mem_bus_pkg::ADDR_W;
  localparam int WAY_W       = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam int LINE_ADDR_W = LT_W + SET_W + LO;

  dcache_pkg::cache_line_t lines [NUM_SETS][NUM_WAYS];
  logic [WAY_W-1:0]        rr_ptr [NUM_SETS];  // per-set replacement pointer

  dcache_pkg::ctrl_state_e        state;
  logic [WA_W-1:0]                miss_wa;    // word address of the pending load
  logic [mem_bus_pkg::TAG_W-1:0]  miss_tag;   // tag given by memory
  logic [mem_bus_pkg::DATA_W-1:0] miss_data;  // held when the fill must wait
  logic                           got_data;

  logic [WA_W-1:0]  rd_wa;
  logic [WA_W-1:0]  wr_wa;
  logic             rd_hit;
  logic             wr_hit;
  logic [WAY_W-1:0] rd_way;
  logic [WAY_W-1:0] wr_way;
  logic [WAY_W-1:0] st_vic_way;
  logic [WAY_W-1:0] fill_vic_way;
  dcache_pkg::cache_line_t st_vic;
  dcache_pkg::cache_line_t fill_vic;
  logic             tag_match;
  logic             fill_now;     // fill cycle, load completes
  logic             st_alloc;     // store miss takes a way
  logic [mem_bus_pkg::DATA_W-1:0] fill_data;

  //////////////////////////////
  // lookup helpers
  //////////////////////////////
  // compare the tag in every way of the set
  function automatic void lookup(input  logic [WA_W-1:0]  wa,
                                 output logic             hit,
                                 output logic [WAY_W-1:0] way);
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (lines[wa[SET_W-1:0]][w].valid &&
          lines[wa[SET_W-1:0]][w].tag[WA_W-1:SET_W] == wa[WA_W-1:SET_W]) begin
        hit = 1'b1;
        way = WAY_W'(w);
      end
    end
  endfunction

  // lowest invalid way, else the round-robin choice
  function automatic logic [WAY_W-1:0] victim(input logic [SET_W-1:0] set);
    logic [WAY_W-1:0] way;
    logic             found;
    way   = rr_ptr[set];
    found = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !lines[set][w].valid) begin
        way   = WAY_W'(w);
        found = 1'b1;
      end
    end
    return way;
  endfunction

  function automatic logic [WAY_W-1:0] next_way(input logic [WAY_W-1:0] way);
    return (way == WAY_W'(NUM_WAYS - 1)) ? '0 : way + 1'b1;
  endfunction

  // byte address of a line, rebuilt from its tag and set
  function automatic logic [LINE_ADDR_W-1:0] line_addr_of(
      input dcache_pkg::cache_line_t ln, input logic [SET_W-1:0] set);
    return {ln.tag[WA_W-1:SET_W], set, {LO{1'b0}}};
  endfunction

  //////////////////////////////
  // hit and victim logic
  //////////////////////////////
  assign rd_wa = rd_addr[LO +: WA_W];  // bits above the cached range ignored
  assign wr_wa = wr_addr[LO +: WA_W];

  always_comb begin
    lookup(rd_wa, rd_hit, rd_way);
    lookup(wr_wa, wr_hit, wr_way);
    st_vic_way   = victim(wr_wa[SET_W-1:0]);
    fill_vic_way = victim(miss_wa[SET_W-1:0]);
    st_vic       = lines[wr_wa[SET_W-1:0]][st_vic_way];
    fill_vic     = lines[miss_wa[SET_W-1:0]][fill_vic_way];
  end

  assign tag_match = (state == dcache_pkg::wait_data) && (miss_tag != '0) &&
                     (dmem2proc_tag == miss_tag);
  // a dirty victim needs room in the buffer first
  assign fill_now  = (got_data || tag_match) &&
                     !(fill_vic.valid && fill_vic.dirty && evict.full);
  assign fill_data = got_data ? miss_data : dmem2proc_data;
  assign st_alloc  = wr_mem && !wr_hit;

  always_comb begin
    rd_valid = 1'b0;
    rd_data  = lines[rd_wa[SET_W-1:0]][rd_way].data;
    if (fill_now) begin
      rd_valid = 1'b1;       // returned word goes straight out
      rd_data  = fill_data;
    end else if (rd_mem && rd_hit) begin
      rd_valid = 1'b1;
    end
  end

  // hold the load back until earlier write-backs have landed
  assign proc2dmem_command = (state == dcache_pkg::req && evict.empty) ?
                             mem_bus_pkg::bus_load : mem_bus_pkg::bus_none;
  assign proc2dmem_addr    = ADDR_W'({miss_wa, {LO{1'b0}}});

  always_comb begin
    evict.push      = 1'b0;
    evict.line_addr = line_addr_of(st_vic, wr_wa[SET_W-1:0]);
    evict.line_data = st_vic.data;
    if (fill_now) begin
      evict.push      = fill_vic.valid && fill_vic.dirty;
      evict.line_addr = line_addr_of(fill_vic, miss_wa[SET_W-1:0]);
      evict.line_data = fill_vic.data;
    end else if (st_alloc) begin
      evict.push = st_vic.valid && st_vic.dirty;
    end
  end

  //////////////////////////////
  // miss controller and array
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= dcache_pkg::idle;
      miss_tag <= '0;
      got_data <= 1'b0;
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_ptr[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          lines[s][w].valid <= 1'b0;
          lines[s][w].dirty <= 1'b0;
        end
      end
    end else begin
      case (state)
        dcache_pkg::idle: begin
          if (rd_mem && !rd_hit) begin
            state   <= dcache_pkg::req;
            miss_wa <= rd_wa;
          end
        end
        dcache_pkg::req: begin
          if (proc2dmem_command == mem_bus_pkg::bus_load && dmem2proc_response != '0) begin
            miss_tag <= dmem2proc_response;  // accepted, remember the tag
            state    <= dcache_pkg::wait_data;
          end
        end
        dcache_pkg::wait_data: begin
          if (tag_match && !fill_now) begin
            got_data  <= 1'b1;  // data shows once, keep it
            miss_data <= dmem2proc_data;
          end
          if (fill_now) begin
            lines[miss_wa[SET_W-1:0]][fill_vic_way] <= '{data: fill_data, tag: miss_wa,
                                                         valid: 1'b1, dirty: 1'b0};
            rr_ptr[miss_wa[SET_W-1:0]] <= next_way(fill_vic_way);
            got_data <= 1'b0;
            miss_tag <= '0;
            state    <= dcache_pkg::idle;
          end
        end
        default: state <= dcache_pkg::idle;
      endcase

      if (wr_mem && wr_hit) begin
        lines[wr_wa[SET_W-1:0]][wr_way].data  <= wr_data;
        lines[wr_wa[SET_W-1:0]][wr_way].dirty <= 1'b1;
      end else if (st_alloc) begin
        // whole word written, no fetch needed
        lines[wr_wa[SET_W-1:0]][st_vic_way] <= '{data: wr_data, tag: wr_wa,
                                                 valid: 1'b1, dirty: 1'b1};
        rr_ptr[wr_wa[SET_W-1:0]] <= next_way(st_vic_way);
      end
    end
  end

  // buffer status comes from the other side of the channel
  a_push_not_full: assert property (@(posedge clock) disable iff (reset)
    evict.push |-> !evict.full)
    else $error("dcache: eviction pushed while buffer full");

  a_rd_wr_excl: assert property (@(posedge clock) disable iff (reset)
    !(rd_mem && wr_mem))
    else $error("dcache: load and store issued together");

endmodule

// ==== logic/evict_buffer.sv ====
`timescale 1ns/1ps
/*
 * eviction buffer
 * small FIFO of dirty lines from the data cache, drained in order as
 * stores on the write-back memory port
 */
module evict_buffer #(
  parameter int NUM_WAYS = 2,
  parameter int DEPTH    = 4
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [mem_bus_pkg::TAG_W-1:0]  rmem2proc_response,
  output mem_bus_pkg::bus_cmd_e          proc2rmem_command,
  output logic [mem_bus_pkg::ADDR_W-1:0] proc2rmem_addr,
  output logic [mem_bus_pkg::DATA_W-1:0] proc2rmem_data,
  evict_if.consumer                      evict
);

  // entries keep only the cached part of the address
  localparam int LINE_ADDR_W = dcache_pkg::tag_bits(NUM_WAYS)
                             + dcache_pkg::set_bits(NUM_WAYS)
                             + mem_bus_pkg::WORD_ADDR_LO;
  localparam int ADDR_W = mem_bus_pkg::ADDR_W;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);

  logic [LINE_ADDR_W-1:0]         addr_q [DEPTH];
  logic [mem_bus_pkg::DATA_W-1:0] data_q [DEPTH];
  logic [PTR_W-1:0]               head;   // oldest line, on the bus
  logic [PTR_W-1:0]               tail;   // next free slot
  logic [CNT_W-1:0]               count;
  logic                           do_push;
  logic                           do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // status and bus side
  //////////////////////////////
  assign evict.full  = (count == CNT_W'(DEPTH));
  assign evict.empty = (count == '0);

  assign do_push = evict.push;  // producer keeps push off while full
  assign do_pop  = !evict.empty && (rmem2proc_response != '0);  // store taken

  assign proc2rmem_command = evict.empty ? mem_bus_pkg::bus_none
                                         : mem_bus_pkg::bus_store;
  assign proc2rmem_addr    = ADDR_W'(addr_q[head]);  // zero above the cached range
  assign proc2rmem_data    = data_q[head];

  //////////////////////////////
  // storage and pointers
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (do_push) begin
      addr_q[tail] <= evict.line_addr;
      data_q[tail] <= evict.line_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) tail <= next_ptr(tail);
      if (do_pop)  head <= next_ptr(head);
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);  // both at once keeps it
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= CNT_W'(DEPTH))
    else $error("evict_buffer: count %0d above depth %0d", count, DEPTH);

  // an empty buffer with nothing arriving stays off the bus
  a_quiet_when_empty: assert property (@(posedge clock) disable iff (reset)
    evict.empty && !evict.push |=> proc2rmem_command == mem_bus_pkg::bus_none)
    else $error("evict_buffer: store issued from an empty buffer");

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
/*
 * memory access stage of the load/store path
 * data cache plus eviction buffer, stalls handed back to the pipeline
 */
module mem_stage #(
  parameter int NUM_WAYS = 2,  // cache associativity
  parameter int WB_DEPTH = 4   // eviction buffer entries
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           rd_mem,       // load this cycle
  input  logic [mem_bus_pkg::ADDR_W-1:0] rd_addr,
  input  logic                           wr_mem,       // store this cycle
  input  logic [mem_bus_pkg::ADDR_W-1:0] wr_addr,
  input  logic [mem_bus_pkg::DATA_W-1:0] wr_data,
  input  logic [mem_bus_pkg::DATA_W-1:0] dmem2proc_data,
  input  logic [mem_bus_pkg::TAG_W-1:0]  dmem2proc_tag,
  input  logic [mem_bus_pkg::TAG_W-1:0]  dmem2proc_response,
  input  logic [mem_bus_pkg::TAG_W-1:0]  rmem2proc_response,
  output logic [mem_bus_pkg::DATA_W-1:0] mem_result,
  output logic                           mem_rd_stall,  // load not answered yet
  output logic                           mem_stall,     // hold off loads and stores
  output mem_bus_pkg::bus_cmd_e          proc2dmem_command,
  output logic [mem_bus_pkg::ADDR_W-1:0] proc2dmem_addr,
  output mem_bus_pkg::bus_cmd_e          proc2rmem_command,
  output logic [mem_bus_pkg::ADDR_W-1:0] proc2rmem_addr,
  output logic [mem_bus_pkg::DATA_W-1:0] proc2rmem_data
);

  logic rd_valid;

  evict_if #(.NUM_WAYS(NUM_WAYS)) evict_bus ();

  //////////////////////////////
  // cache and write-back path
  //////////////////////////////
  dcache #(
    .NUM_WAYS (NUM_WAYS)
  ) u_dcache (
    .clock              (clock),
    .reset              (reset),
    .rd_mem             (rd_mem),
    .rd_addr            (rd_addr),
    .wr_mem             (wr_mem),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .dmem2proc_response (dmem2proc_response),
    .dmem2proc_tag      (dmem2proc_tag),
    .dmem2proc_data     (dmem2proc_data),
    .rd_data            (mem_result),
    .rd_valid           (rd_valid),
    .proc2dmem_command  (proc2dmem_command),
    .proc2dmem_addr     (proc2dmem_addr),
    .evict              (evict_bus)
  );

  evict_buffer #(
    .NUM_WAYS (NUM_WAYS),
    .DEPTH    (WB_DEPTH)
  ) u_evict_buffer (
    .clock              (clock),
    .reset              (reset),
    .rmem2proc_response (rmem2proc_response),
    .proc2rmem_command  (proc2rmem_command),
    .proc2rmem_addr     (proc2rmem_addr),
    .proc2rmem_data     (proc2rmem_data),
    .evict              (evict_bus)
  );

  assign mem_rd_stall = rd_mem & ~rd_valid;  // waiting on a miss
  assign mem_stall    = evict_bus.full;      // no room for another victim

endmodule

// ==== test/mem_model.sv ====
`timescale 1ns/1ps
/*
 * behavioral memory for the memory stage testbench
 * serves the tagged data port and the write-back port from one array,
 * with random acceptance and data delays
 */
module mem_model #(
  parameter logic [31:0] SEED = 32'h8c79
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  hold_wb,       // refuse write-backs while set
  input  mem_bus_pkg::bus_cmd_e dmem_command,
  input  logic [63:0]           dmem_addr,
  output logic [3:0]            dmem_response,
  output logic [3:0]            dmem_tag,
  output logic [63:0]           dmem_data,
  input  mem_bus_pkg::bus_cmd_e rmem_command,
  input  logic [63:0]           rmem_addr,
  input  logic [63:0]           rmem_data,
  output logic [3:0]            rmem_response
);

  logic [63:0] mem [8192];   // indexed by the 13-bit word address
  logic [31:0] rng;
  logic [3:0]  tag_q;        // last tag handed out
  logic [1:0]  ld_state;     // 0 idle, 1 accept delay, 2 data delay
  logic [2:0]  ld_wait;
  logic [12:0] ld_addr;
  logic [3:0]  ld_tag;
  logic [1:0]  wb_state;     // 0 idle, 1 accept delay, 2 settle
  logic [2:0]  wb_wait;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [3:0] bump_tag(input logic [3:0] t);
    return (t == 4'd15) ? 4'd1 : t + 4'd1;  // zero never used
  endfunction

  initial begin
    for (int i = 0; i < 8192; i++) begin
      mem[i] = 64'(i) ^ 64'h5a5a_0000_0000_0000;
    end
    rng = SEED;
  end

  always @(posedge clock) begin
    if (reset) begin
      dmem_response <= '0;
      dmem_tag      <= '0;
      dmem_data     <= '0;
      rmem_response <= '0;
      tag_q         = '0;
      ld_state      <= '0;
      ld_wait       <= '0;
      wb_state      <= '0;
      wb_wait       <= '0;
    end else begin
      dmem_response <= '0;  // pulses last one cycle
      dmem_tag      <= '0;
      rmem_response <= '0;

      //////////////////////////////
      // load side
      //////////////////////////////
      case (ld_state)
        2'd0: if (dmem_command == mem_bus_pkg::bus_load) begin
          rng = xorshift(rng);
          ld_wait  <= rng[2:0];
          ld_addr  <= dmem_addr[15:3];
          ld_state <= 2'd1;
        end
        2'd1: if (ld_wait != 0) begin
          ld_wait <= ld_wait - 3'd1;
        end else begin
          tag_q = bump_tag(tag_q);
          dmem_response <= tag_q;  // accepted now
          ld_tag        <= tag_q;
          rng = xorshift(rng);
          ld_wait  <= rng[2:0];
          ld_state <= 2'd2;
        end
        default: if (ld_wait != 0) begin
          ld_wait <= ld_wait - 3'd1;
        end else begin
          dmem_tag  <= ld_tag;
          dmem_data <= mem[ld_addr];
          ld_state  <= 2'd0;
        end
      endcase

      //////////////////////////////
      // write-back side
      //////////////////////////////
      case (wb_state)
        2'd0: if (rmem_command == mem_bus_pkg::bus_store && !hold_wb) begin
          rng = xorshift(rng);
          wb_wait  <= rng[2:0];
          wb_state <= 2'd1;
        end
        2'd1: if (!hold_wb) begin
          if (wb_wait != 0) begin
            wb_wait <= wb_wait - 3'd1;
          end else begin
            tag_q = bump_tag(tag_q);
            rmem_response <= tag_q;
            mem[rmem_addr[15:3]] <= rmem_data;  // written at acceptance
            wb_state <= 2'd2;
          end
        end
        default: wb_state <= 2'd0;  // head pops this edge, skip it
      endcase
    end
  end

endmodule

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/1ps
/*
 * testbench for the memory stage
 * drives loads and stores against a golden array, a random-latency
 * memory answers both ports, assertions do the checking
 */
module mem_stage_tb;

  logic                  clock;
  logic                  reset;
  logic                  rd_mem;
  logic                  wr_mem;
  logic                  hold_wb;     // back-pressure on the write-back port
  logic [63:0]           rd_addr;
  logic [63:0]           wr_addr;
  logic [63:0]           wr_data;
  logic [63:0]           dmem2proc_data;
  logic [3:0]            dmem2proc_tag;
  logic [3:0]            dmem2proc_response;
  logic [3:0]            rmem2proc_response;
  logic [63:0]           mem_result;
  logic                  mem_rd_stall;
  logic                  mem_stall;
  mem_bus_pkg::bus_cmd_e proc2dmem_command;
  mem_bus_pkg::bus_cmd_e proc2rmem_command;
  logic [63:0]           proc2dmem_addr;
  logic [63:0]           proc2rmem_addr;
  logic [63:0]           proc2rmem_data;

  logic [63:0] golden [8192];  // expected contents by word address
  logic [63:0] exp_data;       // value the current load must return
  logic        expect_hit;
  logic        expect_miss;    // next load must stall in its first cycle
  logic        quiet;          // just out of reset, nothing may move
  logic [31:0] rng;
  int          wb_seen;        // accepted write-backs

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  mem_stage #(.NUM_WAYS(2), .WB_DEPTH(4)) u_dut (
    .clock, .reset, .rd_mem, .rd_addr, .wr_mem, .wr_addr, .wr_data,
    .dmem2proc_data, .dmem2proc_tag, .dmem2proc_response, .rmem2proc_response,
    .mem_result, .mem_rd_stall, .mem_stall, .proc2dmem_command, .proc2dmem_addr,
    .proc2rmem_command, .proc2rmem_addr, .proc2rmem_data
  );

  mem_model #(.SEED(32'h8c79)) u_mem (
    .clock, .reset, .hold_wb,
    .dmem_command (proc2dmem_command), .dmem_addr (proc2dmem_addr),
    .dmem_response (dmem2proc_response), .dmem_tag (dmem2proc_tag),
    .dmem_data (dmem2proc_data),
    .rmem_command (proc2rmem_command), .rmem_addr (proc2rmem_addr),
    .rmem_data (proc2rmem_data), .rmem_response (rmem2proc_response)
  );

  //////////////////////////////
  // failure reporting
  //////////////////////////////
  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    stop_on_error();
  endtask

  task automatic report_text(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_on_error();
  endtask

  //////////////////////////////
  // checks, sampled mid-cycle
  //////////////////////////////
  a_dmem_idle: assert property (@(negedge clock)
    (reset || quiet) |-> proc2dmem_command == mem_bus_pkg::bus_none)
    else report_mismatch("proc2dmem_command", 64'(proc2dmem_command), 64'(0));
  a_rmem_idle: assert property (@(negedge clock)
    (reset || quiet) |-> proc2rmem_command == mem_bus_pkg::bus_none)
    else report_mismatch("proc2rmem_command", 64'(proc2rmem_command), 64'(0));
  a_rd_stall_low: assert property (@(negedge clock) (reset || quiet) |-> !mem_rd_stall)
    else report_mismatch("mem_rd_stall", 64'(mem_rd_stall), 64'(0));
  a_stall_low: assert property (@(negedge clock) (reset || quiet) |-> !mem_stall)
    else report_mismatch("mem_stall", 64'(mem_stall), 64'(0));

  // a completed load carries the golden word
  a_load_data: assert property (@(negedge clock) disable iff (reset)
    (rd_mem && !mem_rd_stall) |-> mem_result == exp_data)
    else report_mismatch("mem_result", mem_result, exp_data);
  a_load_hit: assert property (@(negedge clock) disable iff (reset)
    (rd_mem && expect_hit) |-> !mem_rd_stall)
    else report_mismatch("mem_rd_stall", 64'(mem_rd_stall), 64'(0));
  a_load_miss: assert property (@(negedge clock) disable iff (reset)
    (rd_mem && expect_miss) |-> mem_rd_stall)
    else report_mismatch("mem_rd_stall", 64'(mem_rd_stall), 64'(1));
  a_no_issue_stalled: assert property (@(negedge clock) disable iff (reset)
    mem_stall |-> !(rd_mem || wr_mem))
    else report_text("load or store issued while mem_stall was high");

  always @(negedge clock) begin
    if (!reset && proc2rmem_command == mem_bus_pkg::bus_store && rmem2proc_response != 0)
      wb_seen++;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #2;  // inputs move just after the edge
  endtask

  task automatic wait_not_full();
    int n;
    n = 0;
    while (mem_stall) begin
      if (n == 8) hold_wb = 1'b0;  // let the buffer drain
      if (n == 200) report_text("timeout waiting for mem_stall to drop");
      next_cycle();
      n++;
    end
  endtask

  task automatic store_word(input logic [12:0] wa, input logic [63:0] data);
    wait_not_full();
    wr_mem      = 1'b1;
    wr_addr     = 64'(wa) << 3;
    wr_data     = data;
    golden[wa]  = data;
    next_cycle();
    wr_mem = 1'b0;
  endtask

  task automatic load_word(input logic [12:0] wa, input logic hit);
    int n;
    wait_not_full();
    exp_data   = golden[wa];
    expect_hit = hit;
    rd_addr    = 64'(wa) << 3;
    rd_mem     = 1'b1;
    n = 0;
    @(negedge clock);
    expect_miss = 1'b0;  // first cycle already sampled
    while (mem_rd_stall) begin  // miss in flight
      if (n == 8) hold_wb = 1'b0;
      if (n == 200) report_text("timeout waiting for a load to complete");
      @(negedge clock);
      n++;
    end
    next_cycle();
    rd_mem     = 1'b0;
    expect_hit = 1'b0;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    logic [12:0] wa;
    logic [31:0] r2;
    int          n;
    int          wb_before;
    for (int i = 0; i < 8192; i++) begin
      golden[i] = 64'(i) ^ 64'h5a5a_0000_0000_0000;  // memory power-up rule
    end
    rng = 32'h8c79;
    reset = 1'b1;
    rd_mem = 1'b0;
    wr_mem = 1'b0;
    hold_wb = 1'b0;
    rd_addr = '0;
    wr_addr = '0;
    wr_data = '0;
    exp_data = '0;
    expect_hit = 1'b0;
    expect_miss = 1'b0;
    quiet = 1'b0;
    wb_seen = 0;
    repeat (16) @(posedge clock);
    #2 reset = 1'b0;
    quiet = 1'b1;
    repeat (3) next_cycle();
    quiet = 1'b0;

    expect_miss = 1'b1;
    load_word(13'h123, 1'b0);                  // cold miss
    store_word(13'h040, 64'hdead_beef_0000_0001);
    load_word(13'h040, 1'b1);                  // must hit

    // four tags in set 3, two ways
    wb_before = wb_seen;
    for (int k = 0; k < 4; k++) begin
      store_word(13'(3 + 16 * k), {32'hc0de_0000 | 32'(k), rng});
    end
    for (int k = 0; k < 4; k++) begin
      load_word(13'(3 + 16 * k), 1'b0);
    end
    n = 0;
    while (wb_seen < wb_before + 2) begin
      if (n == 200) report_text("dirty evictions never reached the write-back port");
      next_cycle();
      n++;
    end

    // hold write-backs until the buffer fills
    hold_wb = 1'b1;
    n = 0;
    while (!mem_stall && n < 12) begin
      store_word(13'(7 + 16 * n), {32'hfeed_0000 | 32'(n), ~rng});
      n++;
    end
    if (!mem_stall) report_text("mem_stall never rose with write-backs held");
    repeat (4) next_cycle();
    hold_wb = 1'b0;
    for (int k = 0; k < n; k++) begin
      load_word(13'(7 + 16 * k), 1'b0);
    end

    // random mix over 64 words, 4 tags per set
    for (int i = 0; i < 400; i++) begin
      rng = xorshift(rng);
      if (rng[10:8] == 3'd0) hold_wb = ~hold_wb;
      wa = {7'd0, rng[5:0]};
      if (rng[6]) begin
        r2 = xorshift(rng);
        store_word(wa, {r2, rng});
        rng = r2;
      end else begin
        load_word(wa, 1'b0);
      end
    end
    hold_wb = 1'b0;
    repeat (4) next_cycle();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== files.f ====
logic/mem_bus_pkg.sv
logic/dcache_pkg.sv
logic/evict_if.sv
logic/dcache.sv
logic/evict_buffer.sv
logic/mem_stage.sv
test/mem_model.sv
test/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_stage_tb \
  -Mdir obj_dir -o sim \
  -f files.f

# the simulator exits nonzero on $fatal, the log decides the result
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
